//--- hdl/exec_pkg.sv
// Micro-operation encodings and data widths used by the execute stage
`default_nettype none

package exec_pkg;

    localparam int XLEN       = 32;                // Data path width
    localparam int REG_ADDR_W = 5;                 // Register file address width
    localparam int SHAMT_W    = 5;                 // Shift amount bits taken from operand 2
    localparam int ALU_OP_W   = 4;
    localparam int MUL_OP_W   = 2;
    localparam int BR_COND_W  = 3;
    localparam int KIND_W     = 2;

    // Which unit produces the writeback result
    typedef enum logic [0:0] {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0,                         // Also used for branch and jump targets
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,                         // Answer from upstream lt flag
        ALU_SLTU   = 4'd9,                         // Answer from upstream ltu flag
        ALU_PASS_B = 4'd10                         // LUI style pass of operand 2
    } alu_op_e;

    typedef enum logic [MUL_OP_W-1:0] {
        MUL_MUL    = 2'd0,                         // Low word
        MUL_MULH   = 2'd1,                         // High word signed x signed
        MUL_MULHSU = 2'd2,                         // High word signed x unsigned
        MUL_MULHU  = 2'd3                          // High word unsigned x unsigned
    } mul_op_e;

    typedef enum logic [BR_COND_W-1:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

    typedef enum logic [KIND_W-1:0] {
        KIND_OTHER  = 2'd0,
        KIND_BRANCH = 2'd1,                        // Taken only if condition holds
        KIND_JUMP   = 2'd2                         // Always taken
    } instr_kind_e;

    typedef enum logic [0:0] {
        WB_RESULT = 1'b0,                          // Unit result to rd
        WB_LINK   = 1'b1                           // PC+4 to rd
    } wb_sel_e;

    // Decoded micro-operation, 11 bits
    typedef struct packed {
        unit_e    unit;
        alu_op_e  alu_op;
        mul_op_e  mul_op;
        br_cond_e br_cond;
        wb_sel_e  wb_sel;
    } uop_t;

endpackage

`default_nettype wire

//--- hdl/core_pkg.sv
// Pipeline payloads exchanged between decode, execute, writeback and branch predictor
`default_nettype none

package core_pkg;

    // Operand relation, computed in decode after forwarding
    typedef struct packed {
        logic lt;                                  // Signed less than
        logic ltu;                                 // Unsigned less than
        logic eq;                                  // Equal
    } cmp_flags_t;

    // One instruction entering execute
    typedef struct packed {
        exec_pkg::uop_t                    uop;
        logic                              rd_we;      // Write rd at writeback
        logic [exec_pkg::REG_ADDR_W-1:0]   rd_addr;
        logic [exec_pkg::XLEN-1:0]         pc;         // PC of this instruction
        logic [exec_pkg::XLEN-1:0]         pc_plus4;   // Link value
        logic [exec_pkg::XLEN-1:0]         op1;        // Final forwarded operand
        logic [exec_pkg::XLEN-1:0]         op2;        // Forwarded or immediate
        cmp_flags_t                        cmp;
        exec_pkg::instr_kind_e             kind;
    } ex_req_t;

    // Fetch redirect, same cycle as the request
    typedef struct packed {
        logic [exec_pkg::XLEN-1:0] target;         // pc+imm or rs1+imm
        logic                      taken;
    } redirect_t;

    // Branch predictor training info
    typedef struct packed {
        logic [exec_pkg::XLEN-1:0] pc;             // PC of resolving instruction
        exec_pkg::instr_kind_e     kind;
        logic                      pred_ok;        // Decode holds the right path
    } bp_update_t;

    // Registered writeback payload
    typedef struct packed {
        logic                            we;
        logic [exec_pkg::REG_ADDR_W-1:0] rd_addr;
        exec_pkg::wb_sel_e               wb_sel;    // Picked in writeback
        logic [exec_pkg::XLEN-1:0]       pc_plus4;
        logic [exec_pkg::XLEN-1:0]       result;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/alu_unit.sv
// Integer ALU with arithmetic, logic, shifts and flag-based set-less-than
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  exec_pkg::alu_op_e          op_i,
    input  logic [exec_pkg::XLEN-1:0]  op1_i,
    input  logic [exec_pkg::XLEN-1:0]  op2_i,
    input  core_pkg::cmp_flags_t       cmp_i,    // Upstream comparator flags
    output logic [exec_pkg::XLEN-1:0]  res_o
);

    logic [exec_pkg::SHAMT_W-1:0] shamt;         // Low bits of operand 2
    logic [exec_pkg::XLEN-1:0]    sum;           // Shared adder, also branch target
    logic [exec_pkg::XLEN-1:0]    diff;
    logic [exec_pkg::XLEN-1:0]    sra_res;

    assign shamt   = op2_i[exec_pkg::SHAMT_W-1:0];
    assign sum     = op1_i + op2_i;
    assign diff    = op1_i - op2_i;
    assign sra_res = $signed(op1_i) >>> shamt;    // Sign fill from bit 31

    always_comb begin
        case (op_i)
            exec_pkg::ALU_ADD: begin
                res_o = sum;
            end
            exec_pkg::ALU_SUB: begin
                res_o = diff;
            end
            exec_pkg::ALU_AND: begin
                res_o = op1_i & op2_i;
            end
            exec_pkg::ALU_OR: begin
                res_o = op1_i | op2_i;
            end
            exec_pkg::ALU_XOR: begin
                res_o = op1_i ^ op2_i;
            end
            exec_pkg::ALU_SLL: begin
                res_o = op1_i << shamt;
            end
            exec_pkg::ALU_SRL: begin
                res_o = op1_i >> shamt;           // Zero fill
            end
            exec_pkg::ALU_SRA: begin
                res_o = sra_res;
            end
            exec_pkg::ALU_SLT: begin
                res_o = {{(exec_pkg::XLEN-1){1'b0}}, cmp_i.lt};   // No second comparator
            end
            exec_pkg::ALU_SLTU: begin
                res_o = {{(exec_pkg::XLEN-1){1'b0}}, cmp_i.ltu};
            end
            exec_pkg::ALU_PASS_B: begin
                res_o = op2_i;                    // Immediate pass for LUI
            end
            default: begin
                res_o = sum;                      // Unused codes act as ADD
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
// Single-cycle 32x32 multiplier returning the low or high product word
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  exec_pkg::mul_op_e          op_i,
    input  logic [exec_pkg::XLEN-1:0]  op1_i,
    input  logic [exec_pkg::XLEN-1:0]  op2_i,
    output logic [exec_pkg::XLEN-1:0]  res_o
);

    logic                             a_signed;   // Treat op1 as signed
    logic                             b_signed;   // Treat op2 as signed
    logic signed [2*exec_pkg::XLEN-1:0] a_ext;
    logic signed [2*exec_pkg::XLEN-1:0] b_ext;
    logic signed [2*exec_pkg::XLEN-1:0] prod;     // Low 64 bits are exact

    assign a_signed = (op_i == exec_pkg::MUL_MULH) || (op_i == exec_pkg::MUL_MULHSU);
    assign b_signed = (op_i == exec_pkg::MUL_MULH);

    // Extension to full product width encodes signedness
    assign a_ext = {{exec_pkg::XLEN{a_signed & op1_i[exec_pkg::XLEN-1]}}, op1_i};
    assign b_ext = {{exec_pkg::XLEN{b_signed & op2_i[exec_pkg::XLEN-1]}}, op2_i};

    assign prod = a_ext * b_ext;

    always_comb begin
        if (op_i == exec_pkg::MUL_MUL) begin
            res_o = prod[exec_pkg::XLEN-1:0];                  // Low word, sign agnostic
        end else begin
            res_o = prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN];   // High word
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_resolve.sv
// Branch condition check, fetch redirect and predictor update
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
    input  core_pkg::ex_req_t          req_i,
    input  logic [exec_pkg::XLEN-1:0]  target_i,     // From ALU adder
    input  logic [exec_pkg::XLEN-1:0]  dec_pc_i,     // PC now in decode
    output core_pkg::redirect_t        redirect_o,
    output core_pkg::bp_update_t       bp_update_o
);

    logic cond_ok;                                   // Branch condition holds
    logic taken;
    logic pred_ok;

    always_comb begin
        case (req_i.uop.br_cond)
            exec_pkg::BR_EQ:  cond_ok =  req_i.cmp.eq;
            exec_pkg::BR_NE:  cond_ok = !req_i.cmp.eq;
            exec_pkg::BR_LT:  cond_ok =  req_i.cmp.lt;
            exec_pkg::BR_GE:  cond_ok = !req_i.cmp.lt;
            exec_pkg::BR_LTU: cond_ok =  req_i.cmp.ltu;
            exec_pkg::BR_GEU: cond_ok = !req_i.cmp.ltu;
            default:          cond_ok = 1'b0;        // NONE and spare code never redirect
        endcase
    end

    // Jumps always go, branches only on a true condition
    assign taken = (req_i.kind == exec_pkg::KIND_JUMP) ||
                   ((req_i.kind == exec_pkg::KIND_BRANCH) && cond_ok);

    // Decode must hold the instruction on the resolved path
    assign pred_ok = taken ? (dec_pc_i == target_i)
                           : (dec_pc_i == req_i.pc_plus4);

    always_comb begin
        redirect_o.target   = target_i;
        redirect_o.taken    = taken;
        bp_update_o.pc      = req_i.pc;              // BTB index
        bp_update_o.kind    = req_i.kind;
        bp_update_o.pred_ok = pred_ok;
    end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
// Execute stage top with ALU, multiplier, branch resolution and writeback register
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  core_pkg::ex_req_t          req_i,
    input  logic [exec_pkg::XLEN-1:0]  dec_pc_i,       // For prediction check
    output core_pkg::redirect_t        redirect_o,     // Same cycle
    output core_pkg::bp_update_t       bp_update_o,    // Same cycle
    output core_pkg::wb_t              wb_o            // One cycle later
);

    logic [exec_pkg::XLEN-1:0] alu_res;                // Also the redirect target
    logic [exec_pkg::XLEN-1:0] mul_res;
    logic [exec_pkg::XLEN-1:0] unit_res;
    core_pkg::wb_t             wb_d;                   // Next writeback payload

    alu_unit i_alu_unit (
        .op_i  (req_i.uop.alu_op),
        .op1_i (req_i.op1),
        .op2_i (req_i.op2),
        .cmp_i (req_i.cmp),
        .res_o (alu_res)
    );

    mul_unit i_mul_unit (
        .op_i  (req_i.uop.mul_op),
        .op1_i (req_i.op1),
        .op2_i (req_i.op2),
        .res_o (mul_res)
    );

    branch_resolve i_branch_resolve (
        .req_i       (req_i),
        .target_i    (alu_res),                        // Adder output is pc+imm or rs1+imm
        .dec_pc_i    (dec_pc_i),
        .redirect_o  (redirect_o),
        .bp_update_o (bp_update_o)
    );

    // Result source
    assign unit_res = (req_i.uop.unit == exec_pkg::UNIT_MUL) ? mul_res : alu_res;

    always_comb begin
        wb_d.we       = req_i.rd_we;
        wb_d.rd_addr  = req_i.rd_addr;
        wb_d.wb_sel   = req_i.uop.wb_sel;             // Link choice made downstream
        wb_d.pc_plus4 = req_i.pc_plus4;
        wb_d.result   = unit_res;
    end

    // Writeback register, a new request every cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o <= '0;                                // No write after reset
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// Testbench clock and reset source, 100 ns period and a 10-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;                // Half of the 100 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);              // Reset held for 10 cycles
        rst_o <= 1'b0;                             // Released on a rising edge
    end

endmodule

`default_nettype wire

//--- verif/exec_stage_props.sv
// Bound checks of execute stage outputs against the ISA rules
`timescale 1ns/1ps
`default_nettype none

module exec_stage_props (
    input logic                      clk_i,
    input logic                      rst_i,
    input core_pkg::ex_req_t         req_i,
    input logic [exec_pkg::XLEN-1:0] dec_pc_i,
    input core_pkg::redirect_t       redirect_i,
    input core_pkg::bp_update_t      bp_update_i,
    input core_pkg::wb_t             wb_i
);

    core_pkg::ex_req_t prev_req;                   // Request of the last cycle
    logic              prev_ok;                    // prev_req came after reset
    logic [31:0]       exp_res;
    logic [31:0]       exp_target;
    logic              exp_taken;
    logic              exp_pred_ok;
    logic [exec_pkg::REG_ADDR_W+exec_pkg::XLEN+1:0] wb_ctrl;    // we, rd_addr, wb_sel, pc_plus4
    logic [exec_pkg::REG_ADDR_W+exec_pkg::XLEN+1:0] exp_ctrl;
    int unsigned       fail_cnt = 0;               // Read by the testbench top

    function automatic logic [31:0] alu_model(input core_pkg::ex_req_t r);
        case (r.uop.alu_op)
            exec_pkg::ALU_ADD:  return r.op1 + r.op2;
            exec_pkg::ALU_SUB:  return r.op1 - r.op2;
            exec_pkg::ALU_AND:  return r.op1 & r.op2;
            exec_pkg::ALU_OR:   return r.op1 | r.op2;
            exec_pkg::ALU_XOR:  return r.op1 ^ r.op2;
            exec_pkg::ALU_SLL:  return r.op1 << r.op2[4:0];
            exec_pkg::ALU_SRL:  return r.op1 >> r.op2[4:0];
            exec_pkg::ALU_SRA:  return $signed(r.op1) >>> r.op2[4:0];
            exec_pkg::ALU_SLT:  return {31'b0, $signed(r.op1) < $signed(r.op2)};
            exec_pkg::ALU_SLTU: return {31'b0, r.op1 < r.op2};
            default:            return r.op2;      // PASS_B
        endcase
    endfunction

    // Sign extension to 64 bits makes the modular product exact for signed operands
    function automatic logic [31:0] mul_model(input core_pkg::ex_req_t r);
        logic [63:0] p;
        case (r.uop.mul_op)
            exec_pkg::MUL_MULH:   p = {{32{r.op1[31]}}, r.op1} * {{32{r.op2[31]}}, r.op2};
            exec_pkg::MUL_MULHSU: p = {{32{r.op1[31]}}, r.op1} * {32'b0, r.op2};
            default:              p = {32'b0, r.op1} * {32'b0, r.op2};
        endcase
        return (r.uop.mul_op == exec_pkg::MUL_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic taken_model(input core_pkg::ex_req_t r);
        logic c;
        case (r.uop.br_cond)
            exec_pkg::BR_EQ:  c = r.cmp.eq;
            exec_pkg::BR_NE:  c = !r.cmp.eq;
            exec_pkg::BR_LT:  c = r.cmp.lt;
            exec_pkg::BR_GE:  c = !r.cmp.lt;
            exec_pkg::BR_LTU: c = r.cmp.ltu;
            exec_pkg::BR_GEU: c = !r.cmp.ltu;
            default:          c = 1'b0;            // NONE and unknown codes
        endcase
        return (r.kind == exec_pkg::KIND_JUMP) || ((r.kind == exec_pkg::KIND_BRANCH) && c);
    endfunction

    always_ff @(posedge clk_i) begin
        prev_req <= req_i;                         // Reference for next cycle's wb_i
        prev_ok  <= !rst_i;
    end

    always_comb begin
        exp_res     = (prev_req.uop.unit == exec_pkg::UNIT_MUL) ? mul_model(prev_req)
                                                                : alu_model(prev_req);
        exp_taken   = taken_model(req_i);
        exp_target  = req_i.op1 + req_i.op2;
        exp_pred_ok = exp_taken ? (dec_pc_i == exp_target) : (dec_pc_i == req_i.pc_plus4);
        wb_ctrl     = {wb_i.we, wb_i.rd_addr, wb_i.wb_sel, wb_i.pc_plus4};
        exp_ctrl    = {prev_req.rd_we, prev_req.rd_addr, prev_req.uop.wb_sel, prev_req.pc_plus4};
    end

    a_reset_we: assert property (@(posedge clk_i) $fell(rst_i) |-> !wb_i.we)
        else begin
            fail_cnt++;
            $error("error t=%0t wb_o.we got %b exp 0", $time, $sampled(wb_i.we));
        end
    a_wb_result: assert property (@(posedge clk_i) disable iff (rst_i)
        prev_ok |-> wb_i.result == exp_res)
        else begin
            fail_cnt++;
            $error("error t=%0t wb_o.result got %h exp %h", $time,
                   $sampled(wb_i.result), $sampled(exp_res));
        end
    a_wb_ctrl: assert property (@(posedge clk_i) disable iff (rst_i)
        prev_ok |-> wb_ctrl == exp_ctrl)           // Link fields for downstream
        else begin
            fail_cnt++;
            $error("error t=%0t wb_o.{we,rd_addr,wb_sel,pc_plus4} got %h exp %h", $time,
                   $sampled(wb_ctrl), $sampled(exp_ctrl));
        end
    a_taken: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_i.taken == exp_taken)
        else begin
            fail_cnt++;
            $error("error t=%0t redirect_o.taken got %b exp %b", $time,
                   $sampled(redirect_i.taken), $sampled(exp_taken));
        end
    a_target: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i.kind != exec_pkg::KIND_OTHER |-> redirect_i.target == exp_target)
        else begin
            fail_cnt++;
            $error("error t=%0t redirect_o.target got %h exp %h", $time,
                   $sampled(redirect_i.target), $sampled(exp_target));
        end
    a_bp_update: assert property (@(posedge clk_i) disable iff (rst_i)
        bp_update_i == {req_i.pc, req_i.kind, exp_pred_ok})
        else begin
            fail_cnt++;
            $error("error t=%0t bp_update_o got %h exp %h", $time, $sampled(bp_update_i),
                   $sampled({req_i.pc, req_i.kind, exp_pred_ok}));
        end

endmodule

`default_nettype wire

//--- verif/tb_exec_stage.sv
// Testbench for the execute stage with random requests from an LCG
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    logic                      clk;
    logic                      rst;
    core_pkg::ex_req_t         req;
    logic [exec_pkg::XLEN-1:0] dec_pc;
    core_pkg::redirect_t       redirect;
    core_pkg::bp_update_t      bp_update;
    core_pkg::wb_t             wb;
    logic [31:0]               lcg_state;          // Random generator state
    int unsigned               timeout_cnt;
    int unsigned               assert_cnt;

    tb_clk_gen i_tb_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    exec_stage i_exec_stage (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_i       (req),
        .dec_pc_i    (dec_pc),
        .redirect_o  (redirect),
        .bp_update_o (bp_update),
        .wb_o        (wb)
    );

    bind exec_stage exec_stage_props i_exec_stage_props (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .dec_pc_i    (dec_pc_i),
        .redirect_i  (redirect_o),
        .bp_update_i (bp_update_o),
        .wb_i        (wb_o)
    );

    // Steps the LCG and keeps the upper half since low bits cycle fast
    function automatic int unsigned pick(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]} % n;
    endfunction

    function automatic logic [31:0] word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = 16'(pick(65536));
        lo = 16'(pick(65536));
        return {hi, lo};
    endfunction

    task automatic drive_req();
        core_pkg::ex_req_t r;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        r.uop.unit    = exec_pkg::unit_e'(1'(pick(2)));
        r.uop.alu_op  = exec_pkg::alu_op_e'(4'(pick(11)));
        r.uop.mul_op  = exec_pkg::mul_op_e'(2'(pick(4)));
        r.uop.br_cond = exec_pkg::br_cond_e'(3'(pick(8)));    // Code 7 is unused
        r.uop.wb_sel  = exec_pkg::wb_sel_e'(1'(pick(2)));
        r.kind        = exec_pkg::instr_kind_e'(2'(pick(3)));
        r.rd_we       = 1'(pick(2));
        r.rd_addr     = 5'(pick(32));
        r.pc          = word() & 32'hffff_fffc;             // Word aligned
        r.pc_plus4    = r.pc + 32'd4;
        r.op1         = word();
        r.op2         = (pick(8) == 0) ? r.op1 : word();    // Equal operands now and then
        rs1 = r.op1;
        rs2 = r.op2;
        if (r.kind != exec_pkg::KIND_OTHER) begin
            r.uop.unit   = exec_pkg::UNIT_ALU;              // Target from the ALU adder
            r.uop.alu_op = exec_pkg::ALU_ADD;
            rs1 = word();                                   // Compared registers differ from op1/op2
            rs2 = (pick(4) == 0) ? rs1 : word();
        end
        r.cmp.lt  = $signed(rs1) < $signed(rs2);
        r.cmp.ltu = rs1 < rs2;
        r.cmp.eq  = rs1 == rs2;
        req    <= r;
        dec_pc <= (pick(2) == 0) ? r.pc_plus4 : r.op1 + r.op2;  // Right path about half the time
    endtask

    task automatic wait_reset();
        int i;
        for (i = 0; i < 40; i++) begin
            @(negedge clk);
            if (!rst) return;
        end
        timeout_cnt++;
        $display("Timeout: reset was not released within 40 cycles");
    endtask

    task automatic wait_drain();
        int i;
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (wb.pc_plus4 == 32'hffff_fff4) return;       // Marker reached writeback
        end
        timeout_cnt++;
        $display("Timeout: final request never reached writeback");
    endtask

    initial begin
        core_pkg::ex_req_t mark;
        int                n;
        lcg_state   = 32'd74;
        timeout_cnt = 0;
        req         = '0;
        req.rd_we   = 1'b1;                                 // Write request held during reset
        dec_pc      = '0;
        wait_reset();
        for (n = 0; n < 2000; n++) begin
            @(posedge clk);
            drive_req();
        end
        mark          = '0;                                 // Idle request that flags the end
        mark.pc       = 32'hffff_fff0;
        mark.pc_plus4 = 32'hffff_fff4;
        @(posedge clk);
        req <= mark;
        wait_drain();
        @(negedge clk);                                     // Checks of the last edge are done
        assert_cnt = i_exec_stage.i_exec_stage_props.fail_cnt;
        $display("Errors: %0d assertion failures, %0d timeouts", assert_cnt, timeout_cnt);
        if (assert_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/exec_pkg.sv
hdl/core_pkg.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/branch_resolve.sv
hdl/exec_stage.sv
verif/tb_clk_gen.sv
verif/exec_stage_props.sv
verif/tb_exec_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and judge the log
set -u

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f filelist.f --top-module tb_exec_stage \
    -Mdir "$OBJ" -o sim_exec_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
"$OBJ"/sim_exec_stage +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if grep -q "%Error" "$LOG"; then
    echo "Assertion errors found in $LOG"
    exit 1
fi
exit 0
